// File: src.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_repl.sv
hw/icache_arrays.sv
hw/icache_lookup.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tb/icache_asserts.sv
tb/icache_tb.sv

// File: tb/icache_tb.sv
// instruction cache testbench with clock, reset, stimulus, memory model, reference model and checks
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
;

  logic        clk_i = 1'b0;
  logic        rst_ni, en_i, flush_i, fetch_req_i, mem_ack_i;
  logic [31:0] fetch_addr_i;
  rtrn_type_e  mem_rtrn_type_i;
  rtrn_word_u  mem_rtrn_i;
  logic        fetch_ready_o, fetch_valid_o, mem_req_o, mem_nc_o, miss_o, busy_o;
  logic [31:0] fetch_data_o, fetch_addr_o, mem_addr_o;
  logic [`ICACHE_WAY_BITS-1:0] mem_way_o;

  // reference model with one line address and valid bit per set and way
  logic        mir_vld  [`ICACHE_SETS][`ICACHE_WAYS];
  logic [27:0] mir_line [`ICACHE_SETS][`ICACHE_WAYS];
  logic        model_en;
  // fetches in flight in acceptance order
  logic [31:0] exp_addr_q[$];
  logic        exp_hit_q[$];
  int          exp_cyc_q[$];
  // memory model state
  int          ack_dly, fill_dly, accepted, cyc, tmo_cnt;
  logic        fill_pend, fill_nc, fill_now, inv_now, expect_busy, act, hit;
  logic [31:0] fill_addr, r, seed;
  logic [`ICACHE_WAY_BITS-1:0] fill_way;
  logic        did_flush, did_dis, did_en;
  // lowest invalid way of the fetched set or -1 when none is free
  int          free_way;

  icache_top DUT (.*);

  bind icache_ctrl icache_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .state_q    (state_q),
    .inv_en_o   (inv_en_o),
    .mem_req_o  (mem_req_o),
    .mem_ack_i  (mem_ack_i),
    .mem_addr_o (mem_addr_o),
    .flush_en_o (flush_en_o)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  // every memory word is a hash of its own address
  function automatic logic [31:0] word_hash(logic [31:0] a);
    logic [31:0] h;
    h = {a[31:2], 2'b00} ^ 32'h9e37_79b9;
    h = h ^ (h << 7);
    h = h ^ (h >> 11);
    return h * 32'd2654435761;
  endfunction

  function automatic logic [127:0] line_data(logic [31:0] a);
    logic [127:0] d;
    for (int w = 0; w < 4; w++) begin
      d[w*32 +: 32] = word_hash({a[31:4], w[1:0], 2'b00});
    end
    return d;
  endfunction

  task automatic stop_on_failure(string what);
    $display("%s at %0t", what, $time);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_val(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic clear_mirror();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        mir_vld[s][w] = 1'b0;
      end
    end
  endtask

  // give up when the run is far longer than 400 fetches and the flushes need
  always @(posedge clk_i) begin
    tmo_cnt++;
    if (tmo_cnt >= 6000) begin
      stop_on_failure("timeout: the fetch sequence did not complete");
    end
  end

  initial begin
    seed = 32'h4e2b_6d2d;
    rst_ni = 1'b0;
    en_i = 1'b1;
    flush_i = 1'b0;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    mem_ack_i = 1'b0;
    mem_rtrn_type_i = RTRN_NONE;
    mem_rtrn_i = '0;
    tmo_cnt = 0;
    cyc = 0;
    accepted = 0;
    ack_dly = 0;
    fill_dly = 0;
    fill_pend = 1'b0;
    expect_busy = 1'b0;
    model_en = 1'b1;
    did_flush = 1'b0;
    did_dis = 1'b0;
    did_en = 1'b0;
    clear_mirror();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    // outputs stay quiet and busy stays high through the reset flush
    do begin
      #10;
      compare_val("busy_o", busy_o, 1);
      compare_val("fetch_ready_o", fetch_ready_o, 0);
      compare_val("fetch_valid_o", fetch_valid_o, 0);
      compare_val("mem_req_o", mem_req_o, 0);
      @(negedge clk_i);
    end while (busy_o);

    while (accepted < 400 || exp_addr_q.size() > 0 || fill_pend) begin
      @(negedge clk_i);
      cyc++;
      // a flush requested last cycle has started at the rising edge
      if (expect_busy) begin
        compare_val("busy_o", busy_o, 1);
        expect_busy = 1'b0;
      end
      r = next_rand();
      flush_i = 1'b0;
      fetch_req_i = 1'b0;
      mem_ack_i = 1'b0;
      mem_rtrn_type_i = RTRN_NONE;
      mem_rtrn_i = '0;
      fill_now = 1'b0;
      inv_now = 1'b0;
      act = 1'b0;

      ////////////////////////////////////////////////
      // memory side
      ////////////////////////////////////////////////
      if (fill_pend) begin
        fill_dly--;
        if (fill_dly == 0) begin
          mem_rtrn_type_i = RTRN_FILL;
          mem_rtrn_i.data = line_data(fill_addr);
          fill_now = 1'b1;
        end
      end else if (mem_req_o) begin
        if (ack_dly == 0) begin
          mem_ack_i = 1'b1;
        end else begin
          ack_dly--;
        end
      end

      // flush, enable changes and invalidations only with nothing in flight
      if (!busy_o && !mem_req_o && !fill_pend && exp_addr_q.size() == 0 && accepted < 400) begin
        act = 1'b1;
        if (accepted >= 100 && !did_flush) begin
          flush_i = 1'b1;
          did_flush = 1'b1;
          expect_busy = 1'b1;
          clear_mirror();
        end else if (accepted >= 200 && !did_dis) begin
          en_i = 1'b0;
          did_dis = 1'b1;
          model_en = 1'b0;
        end else if (accepted >= 260 && !did_en) begin
          en_i = 1'b1;
          did_en = 1'b1;
          model_en = 1'b1;
          expect_busy = 1'b1;
          clear_mirror();
        end else if (r[31:28] == 4'h0) begin
          mem_rtrn_type_i = RTRN_INV;
          mem_rtrn_i.inv.cmd.all = r[4];
          mem_rtrn_i.inv.cmd.vld = 1'b1;
          mem_rtrn_i.inv.cmd.way = r[5];
          mem_rtrn_i.inv.cmd.idx = r[3:0];
          inv_now = 1'b1;
        end else begin
          act = 1'b0;
        end
      end
      // 64 lines over 16 sets with a random word and byte offset
      if (!act && accepted < 400 && r[27:26] != 2'b00) begin
        fetch_req_i = 1'b1;
        fetch_addr_i = 32'h8000_0000 | {22'd0, r[13:8], r[1:0], r[21:20]};
      end

      #10;

      ////////////////////////////////////////////////
      // fetch responses
      ////////////////////////////////////////////////
      if (fetch_valid_o) begin
        assert (exp_addr_q.size() > 0)
          else stop_on_failure("fetch_valid_o without a pending fetch");
        compare_val("fetch_addr_o", fetch_addr_o, exp_addr_q[0] & 32'hffff_fffc);
        compare_val("fetch_data_o", fetch_data_o, word_hash(exp_addr_q[0]));
        assert (!exp_hit_q[0] || cyc == exp_cyc_q[0] + 1)
          else stop_on_failure("late hit response");
        // a line the model lacks can only come back with its refill
        assert (exp_hit_q[0] || fill_now)
          else stop_on_failure("hit for a line the model does not hold");
        void'(exp_addr_q.pop_front());
        void'(exp_hit_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end else if (exp_addr_q.size() > 0) begin
        assert (!exp_hit_q[0] || cyc <= exp_cyc_q[0])
          else stop_on_failure("hit not returned after acceptance");
        if (!exp_hit_q[0] && cyc == exp_cyc_q[0] + 1) begin
          compare_val("mem_req_o", mem_req_o, 1);
        end
      end

      if (mem_req_o && mem_ack_i) begin
        assert (exp_addr_q.size() > 0 && !exp_hit_q[0])
          else stop_on_failure("memory request for a hit");
        compare_val("mem_nc_o", mem_nc_o, !model_en);
        compare_val("mem_addr_o", mem_addr_o,
                    exp_addr_q[0] & (model_en ? 32'hffff_fff0 : 32'hffff_fffc));
        compare_val("miss_o", miss_o, model_en);
        // the victim is the lowest way that the model holds as invalid
        if (model_en) begin
          free_way = -1;
          for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!mir_vld[exp_addr_q[0][7:4]][w]) begin
              free_way = w;
            end
          end
          if (free_way >= 0) begin
            compare_val("mem_way_o", mem_way_o, free_way);
          end
        end
        fill_addr = mem_addr_o;
        fill_nc = mem_nc_o;
        fill_way = mem_way_o;
        fill_pend = 1'b1;
        fill_dly = 1 + (r[17:16]);
        ack_dly = r[19:18];
      end else begin
        compare_val("miss_o", miss_o, 0);
      end

      // mirror what the cache wrote or dropped
      if (fill_now) begin
        fill_pend = 1'b0;
        if (!fill_nc) begin
          mir_vld[fill_addr[7:4]][fill_way] = 1'b1;
          mir_line[fill_addr[7:4]][fill_way] = fill_addr[31:4];
        end
      end
      if (inv_now) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          if (r[4] || r[5] == w) begin
            mir_vld[r[3:0]][w] = 1'b0;
          end
        end
      end

      if (fetch_ready_o && fetch_req_i) begin
        hit = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          if (mir_vld[fetch_addr_i[7:4]][w] && mir_line[fetch_addr_i[7:4]][w] == fetch_addr_i[31:4]) begin
            hit = model_en;
          end
        end
        exp_addr_q.push_back(fetch_addr_i);
        exp_hit_q.push_back(hit);
        exp_cyc_q.push_back(cyc);
        accepted++;
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// File: tb/icache_asserts.sv
// concurrent checks on the fetch controller for invalidation timing, request hold and flush length
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_asserts (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic [1:0]                   state_q,
  input logic                         inv_en_o,
  input logic                         mem_req_o,
  input logic                         mem_ack_i,
  input logic [`ICACHE_ADDR_BITS-1:0] mem_addr_o,
  input logic                         flush_en_o
);

  // encoding of the controller state that waits for a fill
  localparam logic [1:0] st_miss = 2'd3;

  //////////////////////////////////////////////////
  // array port use
  //////////////////////////////////////////////////

  // no invalidation arrives while the miss state waits for its fill
  inv_not_in_miss: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (state_q == st_miss) |-> !inv_en_o
  ) else $error("inv_en_o high while a fill is outstanding");

  //////////////////////////////////////////////////
  // memory handshake
  //////////////////////////////////////////////////

  // request and address held until acknowledged
  req_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o)
  ) else $error("mem_req_o dropped or changed before mem_ack_i");

  //////////////////////////////////////////////////
  // flush
  //////////////////////////////////////////////////

  // one set cleared per cycle
  flush_len: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(flush_en_o) |-> ##(`ICACHE_SETS - 1) flush_en_o ##1 !flush_en_o
  ) else $error("flush did not last one cycle per set");

endmodule

// File: hw/icache_top.sv
// two-way set-associative instruction cache top level
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  logic                          flush_i,
  // fetch port
  input  logic                          fetch_req_i,
  input  logic [`ICACHE_ADDR_BITS-1:0]  fetch_addr_i,
  output logic                          fetch_ready_o,
  output logic                          fetch_valid_o,
  output logic [`ICACHE_FETCH_BITS-1:0] fetch_data_o,
  output logic [`ICACHE_ADDR_BITS-1:0]  fetch_addr_o,
  // memory port
  output logic                          mem_req_o,
  input  logic                          mem_ack_i,
  output logic [`ICACHE_ADDR_BITS-1:0]  mem_addr_o,
  output logic                          mem_nc_o,
  output logic [`ICACHE_WAY_BITS-1:0]   mem_way_o,
  input  rtrn_type_e                    mem_rtrn_type_i,
  input  rtrn_word_u                    mem_rtrn_i,
  // performance counting
  output logic                          miss_o,
  output logic                          busy_o
);

  logic                                            rden, wren, flush_en, inv_en;
  logic                                            cmp_en, hit, flush_done;
  logic [`ICACHE_SET_BITS-1:0]                     index;
  logic [`ICACHE_OFFSET_BITS-3:0]                  offset;
  logic [`ICACHE_TAG_BITS-1:0]                     tag;
  logic [`ICACHE_WAY_BITS-1:0]                     repl_way;
  logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_BITS-1:0]   tag_rdata;
  logic [`ICACHE_WAYS-1:0]                         vld_rdata;
  logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_BITS-1:0]  line_rdata;

  icache_ctrl i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_type_i (mem_rtrn_type_i),
    .hit_i           (hit),
    .flush_done_i    (flush_done),
    .repl_way_i      (repl_way),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_addr_o    (fetch_addr_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_way_o       (mem_way_o),
    .miss_o          (miss_o),
    .busy_o          (busy_o),
    .rden_o          (rden),
    .wren_o          (wren),
    .flush_en_o      (flush_en),
    .inv_en_o        (inv_en),
    .cmp_en_o        (cmp_en),
    .index_o         (index),
    .offset_o        (offset),
    .tag_o           (tag)
  );

  // the fill goes to the way that was requested from memory
  icache_arrays i_arrays (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rden_i       (rden),
    .wren_i       (wren),
    .flush_en_i   (flush_en),
    .inv_en_i     (inv_en),
    .index_i      (index),
    .tag_i        (tag),
    .way_i        (mem_way_o),
    .rtrn_i       (mem_rtrn_i),
    .tag_rdata_o  (tag_rdata),
    .vld_rdata_o  (vld_rdata),
    .line_rdata_o (line_rdata),
    .flush_done_o (flush_done)
  );

  icache_lookup i_lookup (
    .tag_i        (tag),
    .offset_i     (offset),
    .cmp_en_i     (cmp_en),
    .tag_rdata_i  (tag_rdata),
    .vld_rdata_i  (vld_rdata),
    .line_rdata_i (line_rdata),
    .rtrn_i       (mem_rtrn_i),
    .hit_o        (hit),
    .data_o       (fetch_data_o)
  );

  icache_repl i_repl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .vld_rdata_i (vld_rdata),
    .wren_i      (wren),
    .way_o       (repl_way)
  );

endmodule

// File: hw/icache_ctrl.sv
// fetch controller: fsm, enable and flush latches, request registers, memory request
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            en_i,
  input  logic                            flush_i,
  input  logic                            fetch_req_i,
  input  logic [`ICACHE_ADDR_BITS-1:0]    fetch_addr_i,
  input  logic                            mem_ack_i,
  input  rtrn_type_e                      mem_rtrn_type_i,
  input  logic                            hit_i,
  input  logic                            flush_done_i,
  input  logic [`ICACHE_WAY_BITS-1:0]     repl_way_i,
  output logic                            fetch_ready_o,
  output logic                            fetch_valid_o,
  output logic [`ICACHE_ADDR_BITS-1:0]    fetch_addr_o,
  output logic                            mem_req_o,
  output logic [`ICACHE_ADDR_BITS-1:0]    mem_addr_o,
  output logic                            mem_nc_o,
  output logic [`ICACHE_WAY_BITS-1:0]     mem_way_o,
  output logic                            miss_o,
  output logic                            busy_o,
  output logic                            rden_o,
  output logic                            wren_o,
  output logic                            flush_en_o,
  output logic                            inv_en_o,
  output logic                            cmp_en_o,
  output logic [`ICACHE_SET_BITS-1:0]     index_o,
  output logic [`ICACHE_OFFSET_BITS-3:0]  offset_o,
  output logic [`ICACHE_TAG_BITS-1:0]     tag_o
);

  localparam logic [1:0] st_flush = 2'd0;
  localparam logic [1:0] st_idle  = 2'd1;
  localparam logic [1:0] st_read  = 2'd2;
  localparam logic [1:0] st_miss  = 2'd3;

  logic [1:0]                      state_d, state_q;
  // cache enabled, only changes in idle and at the end of a flush
  logic                            cache_en_d, cache_en_q;
  // flush waiting to start
  logic                            flush_d, flush_q;
  // tag compare valid in the next cycle
  logic                            cmp_en_d, cmp_en_q;
  // invalidation wrote the valid array last cycle
  logic                            inv_q;
  logic [`ICACHE_WAY_BITS-1:0]     repl_way_q;
  logic [`ICACHE_ADDR_BITS-1:0]    addr_q;
  logic                            accept;

  assign accept = fetch_ready_o & fetch_req_i;

  //////////////////////////////////////////////////
  // address split and memory request fields
  //////////////////////////////////////////////////

  // the arrays are read with the new index in the cycle of acceptance
  assign index_o  = accept ? fetch_addr_i[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS] :
                             addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
  assign tag_o    = addr_q[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
  // word index inside the line
  assign offset_o = addr_q[`ICACHE_OFFSET_BITS-1:2];

  assign fetch_addr_o = {addr_q[`ICACHE_ADDR_BITS-1:2], 2'b00};

  // line request when cacheable, single word when disabled
  assign mem_nc_o   = ~cache_en_q;
  assign mem_addr_o = cache_en_q ?
                      {addr_q[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}} :
                      {addr_q[`ICACHE_ADDR_BITS-1:2], 2'b00};
  // way choice is live in the compare cycle, latched afterwards
  assign mem_way_o  = cmp_en_q ? repl_way_i : repl_way_q;

  assign inv_en_o   = (mem_rtrn_type_i == RTRN_INV);
  assign flush_en_o = (state_q == st_flush);
  assign cmp_en_o   = cmp_en_q;
  assign busy_o     = (state_q != st_idle);

  //////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    cache_en_d    = cache_en_q;
    flush_d       = flush_q | flush_i;
    cmp_en_d      = 1'b0;
    rden_o        = 1'b0;
    wren_o        = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;

    case (state_q)
      // clear every valid bit, one set per cycle
      st_flush: begin
        if (flush_done_i) begin
          state_d    = st_idle;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      st_idle: begin
        cmp_en_d   = cache_en_q;
        // disabling is immediate, enabling goes through a flush
        cache_en_d = cache_en_q & en_i;
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = st_flush;
        end else if (!inv_en_o) begin
          // an invalidation owns the valid array this cycle
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rden_o  = 1'b1;
            state_d = st_read;
          end
        end
      end
      st_read: begin
        cmp_en_d = cache_en_q;
        rden_o   = cache_en_q;
        if (cmp_en_q && inv_q) begin
          // tags came from the invalidated set, look again
        end else if (cmp_en_q && hit_i) begin
          fetch_valid_o = 1'b1;
          state_d       = st_idle;
          // overlap the next fetch unless a flush or invalidation waits
          if (!inv_en_o && !flush_d) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              state_d = st_read;
            end
          end
        end else begin
          // miss, or any fetch while disabled
          cmp_en_d  = 1'b0;
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = cache_en_q;
            state_d = st_miss;
          end
        end
      end
      st_miss: begin
        // fills and invalidations never overlap
        if (mem_rtrn_type_i == RTRN_FILL) begin
          fetch_valid_o = 1'b1;
          wren_o        = cache_en_q;
          state_d       = st_idle;
        end
      end
      default: begin
        state_d = st_flush;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= st_flush;
      cache_en_q <= 1'b0;
      flush_q    <= 1'b0;
      cmp_en_q   <= 1'b0;
      inv_q      <= 1'b0;
      repl_way_q <= '0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      cmp_en_q   <= cmp_en_d;
      inv_q      <= inv_en_o;
      if (cmp_en_q) begin
        repl_way_q <= repl_way_i;
      end
    end
  end

  // request address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

endmodule

// File: hw/icache_lookup.sv
// tag compare, hit way encoding and fetch word select
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_lookup
  import icache_pkg::*;
(
  input  logic [`ICACHE_TAG_BITS-1:0]                        tag_i,
  input  logic [`ICACHE_OFFSET_BITS-3:0]                     offset_i,
  input  logic                                               cmp_en_i,
  input  logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_BITS-1:0]      tag_rdata_i,
  input  logic [`ICACHE_WAYS-1:0]                            vld_rdata_i,
  input  logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_BITS-1:0]     line_rdata_i,
  input  rtrn_word_u                                         rtrn_i,
  output logic                                               hit_o,
  output logic [`ICACHE_FETCH_BITS-1:0]                      data_o
);

  logic [`ICACHE_WAYS-1:0]      way_hit;
  logic [`ICACHE_WAY_BITS-1:0]  hit_way;

  // a tag only matches under its valid bit
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_cmp
    assign way_hit[w] = vld_rdata_i[w] & (tag_rdata_i[w] == tag_i);
  end

  assign hit_o = |way_hit;

  // lowest hitting way, at most one is expected
  always_comb begin
    hit_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_way = w[`ICACHE_WAY_BITS-1:0];
      end
    end
  end

  // hit line after a compare, refill line otherwise
  // an uncached word also sits at its own line offset
  always_comb begin
    if (cmp_en_i) begin
      data_o = line_rdata_i[hit_way][offset_i * `ICACHE_FETCH_BITS +: `ICACHE_FETCH_BITS];
    end else begin
      data_o = rtrn_i.data[offset_i * `ICACHE_FETCH_BITS +: `ICACHE_FETCH_BITS];
    end
  end

endmodule

// File: hw/icache_arrays.sv
// tag, valid and data storage per way, flush counter, valid array address and way enables
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_arrays
  import icache_pkg::*;
(
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               rden_i,
  input  logic                                               wren_i,
  input  logic                                               flush_en_i,
  input  logic                                               inv_en_i,
  input  logic [`ICACHE_SET_BITS-1:0]                        index_i,
  input  logic [`ICACHE_TAG_BITS-1:0]                        tag_i,
  input  logic [`ICACHE_WAY_BITS-1:0]                        way_i,
  input  rtrn_word_u                                         rtrn_i,
  output logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_BITS-1:0]      tag_rdata_o,
  output logic [`ICACHE_WAYS-1:0]                            vld_rdata_o,
  output logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_BITS-1:0]     line_rdata_o,
  output logic                                               flush_done_o
);

  logic [`ICACHE_SET_BITS-1:0]  flush_cnt_q;
  logic [`ICACHE_SET_BITS-1:0]  vld_addr;
  logic [`ICACHE_WAYS-1:0]      vld_req;
  logic                         vld_we;

  // one set per cycle while flushing
  assign flush_done_o = (flush_cnt_q == `ICACHE_SET_BITS'(`ICACHE_SETS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q <= '0;
    end else if (flush_done_o) begin
      flush_cnt_q <= '0;
    end else if (flush_en_i) begin
      flush_cnt_q <= flush_cnt_q + 1'b1;
    end
  end

  // flush over invalidation over fetch
  assign vld_addr = flush_en_i ? flush_cnt_q :
                    inv_en_i   ? rtrn_i.inv.cmd.idx :
                                 index_i;

  // an invalidation must not spill into the other ways of a read
  always_comb begin
    vld_req = '0;
    if (flush_en_i) begin
      vld_req = '1;
    end else if (inv_en_i) begin
      if (rtrn_i.inv.cmd.all) begin
        vld_req = '1;
      end else if (rtrn_i.inv.cmd.vld) begin
        vld_req[rtrn_i.inv.cmd.way] = 1'b1;
      end
    end else if (rden_i) begin
      vld_req = '1;
    end else if (wren_i) begin
      vld_req[way_i] = 1'b1;
    end
  end

  // only a fill sets a valid bit
  assign vld_we = wren_i | inv_en_i | flush_en_i;

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
    logic [`ICACHE_TAG_BITS:0]     tag_mem  [`ICACHE_SETS];
    logic [`ICACHE_LINE_BITS-1:0]  data_mem [`ICACHE_SETS];
    logic [`ICACHE_TAG_BITS:0]     tag_q;
    logic [`ICACHE_LINE_BITS-1:0]  line_q;

    // valid bit on top of the tag
    always_ff @(posedge clk_i) begin
      if (vld_req[w]) begin
        tag_q <= tag_mem[vld_addr];
        if (vld_we) begin
          tag_mem[vld_addr] <= {wren_i, tag_i};
        end
      end
    end

    // all ways read, only the victim way written
    always_ff @(posedge clk_i) begin
      if (rden_i) begin
        line_q <= data_mem[index_i];
      end
      if (wren_i && (way_i == w)) begin
        data_mem[index_i] <= rtrn_i.data;
      end
    end

    assign vld_rdata_o[w]  = tag_q[`ICACHE_TAG_BITS];
    assign tag_rdata_o[w]  = tag_q[`ICACHE_TAG_BITS-1:0];
    assign line_rdata_o[w] = line_q;
  end

endmodule

// File: hw/icache_repl.sv
// replacement way choice: first invalid way, else an lfsr pick
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_repl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [`ICACHE_WAYS-1:0]      vld_rdata_i,
  input  logic                         wren_i,
  output logic [`ICACHE_WAY_BITS-1:0]  way_o
);

  logic                          all_valid;
  logic [`ICACHE_WAY_BITS-1:0]   inv_way;
  logic [`ICACHE_LFSR_BITS-1:0]  lfsr_q;
  logic                          lfsr_fb;

  assign all_valid = &vld_rdata_i;

  // lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!vld_rdata_i[w]) begin
        inv_way = w[`ICACHE_WAY_BITS-1:0];
      end
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // step only when a random victim was consumed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '1;
    end else if (wren_i && all_valid) begin
      lfsr_q <= {lfsr_q[`ICACHE_LFSR_BITS-2:0], lfsr_fb};
    end
  end

  assign way_o = all_valid ? lfsr_q[`ICACHE_WAY_BITS-1:0] : inv_way;

endmodule

// File: hw/icache_pkg.sv
// instruction cache types: return kind, invalidation command, refill word
`include "icache_settings.svh"

package icache_pkg;

  // kind of word on the return path
  typedef enum logic [1:0] {
    RTRN_NONE = 2'd0,
    RTRN_FILL = 2'd1,
    RTRN_INV  = 2'd2
  } rtrn_type_e;

  // invalidation of one set
  // all wins over vld, way only counts with vld
  typedef struct packed {
    logic                        all;
    logic                        vld;
    logic [`ICACHE_WAY_BITS-1:0] way;
    logic [`ICACHE_SET_BITS-1:0] idx;
  } inv_cmd_t;

  // refill word
  // a fill carries a whole line, an invalidation sits in the low bits
  typedef union packed {
    logic [`ICACHE_LINE_BITS-1:0] data;
    struct packed {
      logic [`ICACHE_LINE_BITS-$bits(inv_cmd_t)-1:0] pad;
      inv_cmd_t                                      cmd;
    } inv;
  } rtrn_word_u;

endpackage

// File: hw/icache_settings.svh
// instruction cache geometry, address split, flush length and replacement lfsr width
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// physical fetch address
`define ICACHE_ADDR_BITS 32

// one line is four fetch words
`define ICACHE_LINE_BITS 128
`define ICACHE_FETCH_BITS 32

// two ways
`define ICACHE_WAYS 2
`define ICACHE_WAY_BITS 1

// sets, also the flush length in cycles
`define ICACHE_SETS 16
`define ICACHE_SET_BITS 4

// address split: tag | set | byte offset
`define ICACHE_OFFSET_BITS 4
`define ICACHE_TAG_BITS 24

// random replacement source
`define ICACHE_LFSR_BITS 8

`endif
